/* bootrom.hex */
// Each line is one 256-bit ROM word. The leftmost byte lands in byte lane 0.
000102030405060708090a0b0c0d0e0f00102030405060708090a0b0c0d0e0f0
101112131415161718191a1b1c1d1e1f01112131415161718191a1b1c1d1e1f1
202122232425262728292a2b2c2d2e2f02122232425262728292a2b2c2d2e2f2
303132333435363738393a3b3c3d3e3f03132333435363738393a3b3c3d3e3f3
404142434445464748494a4b4c4d4e4f04142434445464748494a4b4c4d4e4f4
505152535455565758595a5b5c5d5e5f05152535455565758595a5b5c5d5e5f5
606162636465666768696a6b6c6d6e6f06162636465666768696a6b6c6d6e6f6
707172737475767778797a7b7c7d7e7f07172737475767778797a7b7c7d7e7f7
808182838485868788898a8b8c8d8e8f08182838485868788898a8b8c8d8e8f8
909192939495969798999a9b9c9d9e9f09192939495969798999a9b9c9d9e9f9
a0a1a2a3a4a5a6a7a8a9aaabacadaeaf0a1a2a3a4a5a6a7a8a9aaabacadaeafa
b0b1b2b3b4b5b6b7b8b9babbbcbdbebf0b1b2b3b4b5b6b7b8b9babbbcbdbebfb
c0c1c2c3c4c5c6c7c8c9cacbcccdcecf0c1c2c3c4c5c6c7c8c9cacbcccdcecfc
d0d1d2d3d4d5d6d7d8d9dadbdcdddedf0d1d2d3d4d5d6d7d8d9dadbdcdddedfd
e0e1e2e3e4e5e6e7e8e9eaebecedeeef0e1e2e3e4e5e6e7e8e9eaebecedeeefe
f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff0f1f2f3f4f5f6f7f8f9fafbfcfdfefff

/* common/l2_mem_pkg.sv */
package l2_mem_pkg;

// Command carried with every L2 request.
typedef enum logic {
  MEM_RD = 1'b0,
  MEM_WR = 1'b1
} mem_cmd_t;

// Data path widths.
localparam int L2_DATA_W = 256;
localparam int L2_BE_W = L2_DATA_W / 8;
localparam int L2_TAG_W = 4;
localparam int L2_ADDR_W = 16;

// Byte offset bits inside one data word.
localparam int WORD_OFFSET_W = $clog2(L2_BE_W);

// Address map. Anything outside the ROM window lands in the scratch RAM.
localparam logic [L2_ADDR_W-1:0] BOOTROM_BASE = 16'h1000;
localparam int BOOTROM_SIZE = 512;
localparam int RAM_SIZE = 1024;

localparam int ROM_WORDS = BOOTROM_SIZE / L2_BE_W;
localparam int RAM_WORDS = RAM_SIZE / L2_BE_W;
localparam int ROM_WORD_W = $clog2(ROM_WORDS);
localparam int RAM_WORD_W = $clog2(RAM_WORDS);

// Initial ROM contents, one 256-bit word per line.
localparam string BOOTROM_HEX_FILE = "bootrom.hex";

// Read pipeline depths, strobe to response push.
localparam int ROM_RD_LAT = 4;
localparam int RAM_RD_LAT = 2;

// Response queue depth and the matching credit counter width.
localparam int RESP_FIFO_DEPTH = 4;
localparam int CREDIT_W = $clog2(RESP_FIFO_DEPTH + 1);

endpackage

/* compile.f */
common/l2_mem_pkg.sv
src/bootrom.sv
src/scratch_ram.sv
src/l2_addr_router.sv
src/l2_resp_fifo.sv
src/l2_resp_arbiter.sv
src/l2_mem_subsys.sv
+incdir+testbench
testbench/tb_l2_mem_subsys.sv

/* src/bootrom.sv */
module bootrom (
  input  logic                              i_clk,
  input  logic                              i_reset_n,

  input  logic                              i_req,
  input  logic [l2_mem_pkg::ROM_WORD_W-1:0] i_req_word,
  input  logic [l2_mem_pkg::L2_TAG_W-1:0]   i_req_tag,

  output logic                              o_resp_valid,
  output logic [l2_mem_pkg::L2_TAG_W-1:0]   o_resp_tag,
  output logic [l2_mem_pkg::L2_DATA_W-1:0]  o_resp_data
);

import l2_mem_pkg::*;

logic [L2_DATA_W-1:0]  rom_raw [ROM_WORDS];
logic [L2_DATA_W-1:0]  rom     [ROM_WORDS];

logic [ROM_RD_LAT-1:0] pipe_valid;
logic [L2_TAG_W-1:0]   pipe_tag  [ROM_RD_LAT];
logic [L2_DATA_W-1:0]  pipe_data [ROM_RD_LAT];

// The hex file lists bytes most significant first, so each word is swapped
// to put the first byte of the line at byte lane 0.
initial begin
  $readmemh(BOOTROM_HEX_FILE, rom_raw);
  for (int w = 0; w < ROM_WORDS; w++) begin
    rom[w] = {<<8{rom_raw[w]}};
  end
end

always_ff @(posedge i_clk or negedge i_reset_n) begin
  if (!i_reset_n) begin
    pipe_valid <= '0;
  end else begin
    pipe_valid <= {pipe_valid[ROM_RD_LAT-2:0], i_req};
  end
end

// Writes are not special here. Every command reads the addressed word.
always_ff @(posedge i_clk) begin
  if (i_req) begin
    pipe_tag[0]  <= i_req_tag;
    pipe_data[0] <= rom[i_req_word];
  end
  for (int s = 1; s < ROM_RD_LAT; s++) begin
    pipe_tag[s]  <= pipe_tag[s-1];
    pipe_data[s] <= pipe_data[s-1];
  end
end

assign o_resp_valid = pipe_valid[ROM_RD_LAT-1];
assign o_resp_tag   = pipe_tag[ROM_RD_LAT-1];
assign o_resp_data  = pipe_data[ROM_RD_LAT-1];

// The router must only steer addresses inside the ROM window here.
a_word_in_range: assert property (
  @(posedge i_clk) disable iff (!i_reset_n)
  i_req |-> !$isunknown(i_req_word) && (i_req_word < ROM_WORDS)
);

endmodule

/* src/l2_addr_router.sv */
module l2_addr_router (
  input  logic                              i_clk,
  input  logic                              i_reset_n,

  input  logic                              i_req_valid,
  input  logic [l2_mem_pkg::L2_ADDR_W-1:0]  i_req_addr,

  input  logic                              i_rom_pop,
  input  logic                              i_ram_pop,

  output logic                              o_req_ready,
  output logic                              o_rom_req,
  output logic                              o_ram_req,
  output logic [l2_mem_pkg::RAM_WORD_W-1:0] o_word
);

import l2_mem_pkg::*;

logic                  in_rom;
logic [L2_ADDR_W-1:0]  rom_offset;
logic [ROM_WORD_W-1:0] rom_word;
logic [RAM_WORD_W-1:0] ram_word;
logic                  accept;

logic [CREDIT_W-1:0]   rom_credit;
logic [CREDIT_W-1:0]   ram_credit;

assign rom_offset = i_req_addr - BOOTROM_BASE;
assign in_rom     = (i_req_addr >= BOOTROM_BASE) && (rom_offset < BOOTROM_SIZE);

// RAM addresses simply alias on their low bits.
assign rom_word = rom_offset[WORD_OFFSET_W +: ROM_WORD_W];
assign ram_word = i_req_addr[WORD_OFFSET_W +: RAM_WORD_W];
assign o_word   = in_rom ? RAM_WORD_W'(rom_word) : ram_word;

// A credit stands for one free slot in that target's response queue, so
// a request is only taken when its response has somewhere to go.
assign o_req_ready = in_rom ? (rom_credit != '0) : (ram_credit != '0);

assign accept    = i_req_valid && o_req_ready;
assign o_rom_req = accept && in_rom;
assign o_ram_req = accept && !in_rom;

always_ff @(posedge i_clk or negedge i_reset_n) begin
  if (!i_reset_n) begin
    rom_credit <= CREDIT_W'(RESP_FIFO_DEPTH);
    ram_credit <= CREDIT_W'(RESP_FIFO_DEPTH);
  end else begin
    rom_credit <= rom_credit - CREDIT_W'(o_rom_req) + CREDIT_W'(i_rom_pop);
    ram_credit <= ram_credit - CREDIT_W'(o_ram_req) + CREDIT_W'(i_ram_pop);
  end
end

// Pops come back from the arbiter, so an extra pop would show up here.
a_credit_bound: assert property (
  @(posedge i_clk) disable iff (!i_reset_n)
  (rom_credit <= CREDIT_W'(RESP_FIFO_DEPTH)) &&
  (ram_credit <= CREDIT_W'(RESP_FIFO_DEPTH))
);

endmodule

/* src/l2_mem_subsys.sv */
module l2_mem_subsys (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  logic                             i_req_valid,
  input  l2_mem_pkg::mem_cmd_t             i_req_cmd,
  input  logic [l2_mem_pkg::L2_ADDR_W-1:0] i_req_addr,
  input  logic [l2_mem_pkg::L2_TAG_W-1:0]  i_req_tag,
  input  logic [l2_mem_pkg::L2_DATA_W-1:0] i_req_data,
  input  logic [l2_mem_pkg::L2_BE_W-1:0]   i_req_byte_en,
  output logic                             o_req_ready,

  output logic                             o_resp_valid,
  output logic [l2_mem_pkg::L2_TAG_W-1:0]  o_resp_tag,
  output logic [l2_mem_pkg::L2_DATA_W-1:0] o_resp_data,
  input  logic                             i_resp_ready
);

import l2_mem_pkg::*;

logic                  rom_req;
logic                  ram_req;
logic [RAM_WORD_W-1:0] req_word;

logic                  rom_push;
logic [L2_TAG_W-1:0]   rom_push_tag;
logic [L2_DATA_W-1:0]  rom_push_data;
logic                  ram_push;
logic [L2_TAG_W-1:0]   ram_push_tag;
logic [L2_DATA_W-1:0]  ram_push_data;

logic                  rom_not_empty;
logic [L2_TAG_W-1:0]   rom_head_tag;
logic [L2_DATA_W-1:0]  rom_head_data;
logic                  ram_not_empty;
logic [L2_TAG_W-1:0]   ram_head_tag;
logic [L2_DATA_W-1:0]  ram_head_data;

logic                  rom_pop;
logic                  ram_pop;

l2_addr_router l2_addr_router_inst (
  .i_clk, .i_reset_n, .i_req_valid, .i_req_addr,
  .i_rom_pop (rom_pop), .i_ram_pop (ram_pop),
  .o_req_ready, .o_rom_req (rom_req), .o_ram_req (ram_req), .o_word (req_word)
);

// The ROM only sees the low word bits since its window is half the RAM.
bootrom bootrom_inst (
  .i_clk, .i_reset_n,
  .i_req (rom_req), .i_req_word (req_word[ROM_WORD_W-1:0]), .i_req_tag,
  .o_resp_valid (rom_push), .o_resp_tag (rom_push_tag), .o_resp_data (rom_push_data)
);

scratch_ram scratch_ram_inst (
  .i_clk, .i_reset_n,
  .i_req (ram_req), .i_req_cmd, .i_req_word (req_word), .i_req_tag,
  .i_req_data, .i_req_byte_en,
  .o_resp_valid (ram_push), .o_resp_tag (ram_push_tag), .o_resp_data (ram_push_data)
);

l2_resp_fifo #(.DEPTH (RESP_FIFO_DEPTH)) rom_resp_fifo (
  .i_clk, .i_reset_n,
  .i_push (rom_push), .i_tag (rom_push_tag), .i_data (rom_push_data), .i_pop (rom_pop),
  .o_not_empty (rom_not_empty), .o_tag (rom_head_tag), .o_data (rom_head_data)
);

l2_resp_fifo #(.DEPTH (RESP_FIFO_DEPTH)) ram_resp_fifo (
  .i_clk, .i_reset_n,
  .i_push (ram_push), .i_tag (ram_push_tag), .i_data (ram_push_data), .i_pop (ram_pop),
  .o_not_empty (ram_not_empty), .o_tag (ram_head_tag), .o_data (ram_head_data)
);

l2_resp_arbiter l2_resp_arbiter_inst (
  .i_clk, .i_reset_n,
  .i_rom_not_empty (rom_not_empty), .i_rom_tag (rom_head_tag), .i_rom_data (rom_head_data),
  .i_ram_not_empty (ram_not_empty), .i_ram_tag (ram_head_tag), .i_ram_data (ram_head_data),
  .i_resp_ready,
  .o_rom_pop (rom_pop), .o_ram_pop (ram_pop),
  .o_resp_valid, .o_resp_tag, .o_resp_data
);

endmodule

/* src/l2_resp_arbiter.sv */
module l2_resp_arbiter (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  logic                             i_rom_not_empty,
  input  logic [l2_mem_pkg::L2_TAG_W-1:0]  i_rom_tag,
  input  logic [l2_mem_pkg::L2_DATA_W-1:0] i_rom_data,

  input  logic                             i_ram_not_empty,
  input  logic [l2_mem_pkg::L2_TAG_W-1:0]  i_ram_tag,
  input  logic [l2_mem_pkg::L2_DATA_W-1:0] i_ram_data,

  input  logic                             i_resp_ready,

  output logic                             o_rom_pop,
  output logic                             o_ram_pop,

  output logic                             o_resp_valid,
  output logic [l2_mem_pkg::L2_TAG_W-1:0]  o_resp_tag,
  output logic [l2_mem_pkg::L2_DATA_W-1:0] o_resp_data
);

logic sel_ram;
logic handshake;
logic last_ram;
logic lock;
logic lock_ram;

// A stalled response keeps its source so valid and data cannot change
// under the requester.
always_comb begin
  if (lock) begin
    sel_ram = lock_ram;
  end else if (i_rom_not_empty && i_ram_not_empty) begin
    sel_ram = !last_ram;
  end else begin
    sel_ram = i_ram_not_empty;
  end
end

assign o_resp_valid = sel_ram ? i_ram_not_empty : i_rom_not_empty;
assign o_resp_tag   = sel_ram ? i_ram_tag : i_rom_tag;
assign o_resp_data  = sel_ram ? i_ram_data : i_rom_data;

assign handshake = o_resp_valid && i_resp_ready;
assign o_rom_pop = handshake && !sel_ram;
assign o_ram_pop = handshake && sel_ram;

always_ff @(posedge i_clk or negedge i_reset_n) begin
  if (!i_reset_n) begin
    last_ram <= 1'b0;
    lock     <= 1'b0;
    lock_ram <= 1'b0;
  end else begin
    if (handshake) begin
      last_ram <= sel_ram;
    end
    lock     <= o_resp_valid && !i_resp_ready;
    lock_ram <= sel_ram;
  end
end

a_resp_stable: assert property (
  @(posedge i_clk) disable iff (!i_reset_n)
  (o_resp_valid && !i_resp_ready) |=>
    (o_resp_valid && $stable(o_resp_tag) && $stable(o_resp_data))
);

endmodule

/* src/l2_resp_fifo.sv */
module l2_resp_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  logic                             i_push,
  input  logic [l2_mem_pkg::L2_TAG_W-1:0]  i_tag,
  input  logic [l2_mem_pkg::L2_DATA_W-1:0] i_data,

  input  logic                             i_pop,

  output logic                             o_not_empty,
  output logic [l2_mem_pkg::L2_TAG_W-1:0]  o_tag,
  output logic [l2_mem_pkg::L2_DATA_W-1:0] o_data
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

logic [l2_mem_pkg::L2_TAG_W-1:0]  tag_mem  [DEPTH];
logic [l2_mem_pkg::L2_DATA_W-1:0] data_mem [DEPTH];

logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;

always_ff @(posedge i_clk) begin
  if (i_push) begin
    tag_mem[wr_ptr]  <= i_tag;
    data_mem[wr_ptr] <= i_data;
  end
end

always_ff @(posedge i_clk or negedge i_reset_n) begin
  if (!i_reset_n) begin
    wr_ptr <= '0;
    rd_ptr <= '0;
    count  <= '0;
  end else begin
    if (i_push) begin
      wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
    if (i_pop) begin
      rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    end
    count <= count + CNT_W'(i_push) - CNT_W'(i_pop);
  end
end

assign o_not_empty = (count != '0);
assign o_tag       = tag_mem[rd_ptr];
assign o_data      = data_mem[rd_ptr];

// Room is promised by the router's credits, not checked here.
a_no_overflow: assert property (
  @(posedge i_clk) disable iff (!i_reset_n)
  i_push |-> (count < CNT_W'(DEPTH))
);

a_no_underflow: assert property (
  @(posedge i_clk) disable iff (!i_reset_n)
  i_pop |-> (count != '0)
);

endmodule

/* src/scratch_ram.sv */
module scratch_ram (
  input  logic                              i_clk,
  input  logic                              i_reset_n,

  input  logic                              i_req,
  input  l2_mem_pkg::mem_cmd_t              i_req_cmd,
  input  logic [l2_mem_pkg::RAM_WORD_W-1:0] i_req_word,
  input  logic [l2_mem_pkg::L2_TAG_W-1:0]   i_req_tag,
  input  logic [l2_mem_pkg::L2_DATA_W-1:0]  i_req_data,
  input  logic [l2_mem_pkg::L2_BE_W-1:0]    i_req_byte_en,

  output logic                              o_resp_valid,
  output logic [l2_mem_pkg::L2_TAG_W-1:0]   o_resp_tag,
  output logic [l2_mem_pkg::L2_DATA_W-1:0]  o_resp_data
);

import l2_mem_pkg::*;

logic [L2_DATA_W-1:0]  mem [RAM_WORDS];

logic                  is_write;
logic [RAM_RD_LAT-1:0] pipe_valid;
logic [L2_TAG_W-1:0]   pipe_tag  [RAM_RD_LAT];
logic [L2_DATA_W-1:0]  pipe_data [RAM_RD_LAT];

assign is_write = i_req && (i_req_cmd == MEM_WR);

// Byte-lane write. Lanes without an enable keep their old contents.
always_ff @(posedge i_clk) begin
  if (is_write) begin
    for (int b = 0; b < L2_BE_W; b++) begin
      if (i_req_byte_en[b]) begin
        mem[i_req_word][b*8 +: 8] <= i_req_data[b*8 +: 8];
      end
    end
  end
end

always_ff @(posedge i_clk or negedge i_reset_n) begin
  if (!i_reset_n) begin
    pipe_valid <= '0;
  end else begin
    pipe_valid <= {pipe_valid[RAM_RD_LAT-2:0], i_req};
  end
end

// A read samples the array before the same edge's write can land, and a
// write answers with an all-zero word.
always_ff @(posedge i_clk) begin
  if (i_req) begin
    pipe_tag[0] <= i_req_tag;
    if (is_write) begin
      pipe_data[0] <= '0;
    end else begin
      pipe_data[0] <= mem[i_req_word];
    end
  end
  for (int s = 1; s < RAM_RD_LAT; s++) begin
    pipe_tag[s]  <= pipe_tag[s-1];
    pipe_data[s] <= pipe_data[s-1];
  end
end

assign o_resp_valid = pipe_valid[RAM_RD_LAT-1];
assign o_resp_tag   = pipe_tag[RAM_RD_LAT-1];
assign o_resp_data  = pipe_data[RAM_RD_LAT-1];

// An undefined command would silently corrupt the array.
a_cmd_known: assert property (
  @(posedge i_clk) disable iff (!i_reset_n)
  i_req |-> !$isunknown(i_req_cmd) && !$isunknown(i_req_word)
);

endmodule

/* testbench/tb_l2_tasks.svh */
`ifndef TB_L2_TASKS_SVH
`define TB_L2_TASKS_SVH

logic [L2_DATA_W-1:0] rom_raw      [ROM_WORDS];
logic [L2_DATA_W-1:0] rom_model    [ROM_WORDS];
logic [L2_DATA_W-1:0] ram_model    [RAM_WORDS];
logic                 pending      [2**L2_TAG_W];
logic                 pending_rom  [2**L2_TAG_W];
logic [L2_DATA_W-1:0] pending_data [2**L2_TAG_W];
logic [L2_TAG_W-1:0]  rom_order    [$];
logic [L2_TAG_W-1:0]  ram_order    [$];
logic [L2_TAG_W-1:0]  next_tag;
int                   outstanding;
int                   error_count;
int                   max_wait = 500;

task automatic fail_run(input string reason);
  error_count++;
  $display("%s", reason);
  $display("Simulation failed");
  $fatal(1);
endtask

task automatic check_value(input string name, input logic [L2_DATA_W-1:0] actual,
                           input logic [L2_DATA_W-1:0] expected);
  if (actual !== expected) begin
    error_count++;
    $display("error: time %0t, %s = %h, expected %h", $time, name, actual, expected);
    $display("Simulation failed");
    $fatal(1);
  end
endtask

// The file holds the most significant byte first, so lanes are reversed.
task automatic load_rom_model();
  $readmemh("bootrom.hex", rom_raw);
  for (int w = 0; w < ROM_WORDS; w++) begin
    for (int b = 0; b < L2_BE_W; b++) begin
      rom_model[w][b*8 +: 8] = rom_raw[w][(L2_BE_W-1-b)*8 +: 8];
    end
  end
endtask

function automatic logic addr_in_rom(input logic [L2_ADDR_W-1:0] addr);
  return (addr >= BOOTROM_BASE) && (addr < BOOTROM_BASE + BOOTROM_SIZE);
endfunction

task automatic alloc_tag(output logic [L2_TAG_W-1:0] tag);
  int waited;
  waited = 0;
  while (pending[next_tag]) begin
    next_tag++;
    waited++;
    if (waited > max_wait) begin
      fail_run("No free request tag became available.");
    end
    if (waited % 16 == 0) begin
      @(negedge i_clk);
    end
  end
  tag = next_tag;
  next_tag++;
endtask

// Holds the request until o_req_ready, then records the expected response.
task automatic send_request(input mem_cmd_t cmd, input logic [L2_ADDR_W-1:0] addr,
                            input logic [L2_DATA_W-1:0] data,
                            input logic [L2_BE_W-1:0] be, output int stall_cycles);
  logic [L2_TAG_W-1:0] tag;
  logic                to_rom;
  int                  idx;
  alloc_tag(tag);
  to_rom = addr_in_rom(addr);
  @(negedge i_clk);
  i_req_valid   = 1'b1;
  i_req_cmd     = cmd;
  i_req_addr    = addr;
  i_req_tag     = tag;
  i_req_data    = data;
  i_req_byte_en = be;
  stall_cycles  = 0;
  #1;
  while (!o_req_ready) begin
    stall_cycles++;
    if (stall_cycles > max_wait) begin
      fail_run("Timed out waiting for o_req_ready.");
    end
    @(negedge i_clk);
    #1;
  end
  if (to_rom) begin
    idx = (addr - BOOTROM_BASE) >> WORD_OFFSET_W;
    pending_data[tag] = rom_model[idx];
    rom_order.push_back(tag);
  end else begin
    idx = addr[WORD_OFFSET_W +: RAM_WORD_W];
    if (cmd == MEM_WR) begin
      pending_data[tag] = '0;
      for (int b = 0; b < L2_BE_W; b++) begin
        if (be[b]) begin
          ram_model[idx][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end else begin
      pending_data[tag] = ram_model[idx];
    end
    ram_order.push_back(tag);
  end
  pending_rom[tag] = to_rom;
  pending[tag] = 1'b1;
  outstanding++;
  @(negedge i_clk);
  i_req_valid = 1'b0;
endtask

task automatic read_word(input logic [L2_ADDR_W-1:0] addr);
  int stalls;
  send_request(MEM_RD, addr, '0, '0, stalls);
endtask

task automatic write_word(input logic [L2_ADDR_W-1:0] addr, input logic [L2_DATA_W-1:0] data,
                          input logic [L2_BE_W-1:0] be);
  int stalls;
  send_request(MEM_WR, addr, data, be, stalls);
endtask

// Same-target responses must come back in request order.
task automatic accept_response(input logic [L2_TAG_W-1:0] tag,
                               input logic [L2_DATA_W-1:0] data);
  logic [L2_TAG_W-1:0] expected_tag;
  if (!pending[tag]) begin
    fail_run($sformatf("A response with tag %0d arrived with no request outstanding.", tag));
  end
  if (pending_rom[tag]) begin
    expected_tag = rom_order.pop_front();
  end else begin
    expected_tag = ram_order.pop_front();
  end
  check_value("o_resp_tag", tag, expected_tag);
  check_value("o_resp_data", data, pending_data[tag]);
  pending[tag] = 1'b0;
  outstanding--;
endtask

task automatic wait_idle();
  int waited;
  waited = 0;
  while (outstanding != 0) begin
    waited++;
    if (waited > max_wait) begin
      fail_run("Timed out waiting for all outstanding responses.");
    end
    @(negedge i_clk);
  end
endtask

`endif

/* testbench/tb_l2_mem_subsys.sv */
module tb_l2_mem_subsys;

timeunit 1ns;
timeprecision 100ps;

import l2_mem_pkg::*;

logic                 i_clk;
logic                 i_reset_n;
logic                 i_req_valid;
mem_cmd_t             i_req_cmd;
logic [L2_ADDR_W-1:0] i_req_addr;
logic [L2_TAG_W-1:0]  i_req_tag;
logic [L2_DATA_W-1:0] i_req_data;
logic [L2_BE_W-1:0]   i_req_byte_en;
logic                 o_req_ready;
logic                 o_resp_valid;
logic [L2_TAG_W-1:0]  o_resp_tag;
logic [L2_DATA_W-1:0] o_resp_data;
logic                 i_resp_ready;

logic                 mon_enable;
logic                 stall_resp;
logic                 random_resp;
logic                 held_valid;
logic [L2_TAG_W-1:0]  held_tag;
logic [L2_DATA_W-1:0] held_data;

`include "tb_l2_tasks.svh"

l2_mem_subsys l2_mem_subsys_inst (
  .i_clk, .i_reset_n,
  .i_req_valid, .i_req_cmd, .i_req_addr, .i_req_tag, .i_req_data, .i_req_byte_en,
  .o_req_ready,
  .o_resp_valid, .o_resp_tag, .o_resp_data, .i_resp_ready
);

initial begin
  i_clk = 1'b0;
  forever #2 i_clk = ~i_clk;
end

// Drives i_resp_ready and takes each response that completes at the next edge.
always @(negedge i_clk) begin
  if (mon_enable) begin
    if (stall_resp) begin
      i_resp_ready = 1'b0;
    end else if (random_resp) begin
      i_resp_ready = 1'($urandom_range(0, 1));
    end else begin
      i_resp_ready = 1'b1;
    end
    #1;
    if (held_valid) begin
      check_value("o_resp_valid", o_resp_valid, 1'b1);
      check_value("o_resp_tag", o_resp_tag, held_tag);
      check_value("o_resp_data", o_resp_data, held_data);
    end
    held_valid = 1'b0;
    if (o_resp_valid && i_resp_ready) begin
      accept_response(o_resp_tag, o_resp_data);
    end else if (o_resp_valid) begin
      held_valid = 1'b1;
      held_tag = o_resp_tag;
      held_data = o_resp_data;
    end
  end
end

function automatic logic [L2_DATA_W-1:0] fill_word(input int w);
  logic [L2_DATA_W-1:0] v;
  for (int j = 0; j < 8; j++) begin
    v[j*32 +: 32] = {8'h5a, 8'(j), 16'(w)};
  end
  return v;
endfunction

function automatic logic [L2_DATA_W-1:0] rand_word();
  logic [L2_DATA_W-1:0] v;
  for (int j = 0; j < 8; j++) begin
    v[j*32 +: 32] = $urandom;
  end
  return v;
endfunction

task automatic test_reset_state();
  @(negedge i_clk);
  #1;
  check_value("o_resp_valid", o_resp_valid, 1'b0);
  check_value("o_req_ready", o_req_ready, 1'b1);
endtask

task automatic test_rom_reads();
  for (int w = 0; w < ROM_WORDS; w++) begin
    read_word(L2_ADDR_W'(BOOTROM_BASE + w * L2_BE_W + w));
  end
  wait_idle();
  // Writes to the ROM window are answered with the unchanged ROM word.
  write_word(L2_ADDR_W'(BOOTROM_BASE + 3 * L2_BE_W), '1, '1);
  read_word(L2_ADDR_W'(BOOTROM_BASE + 3 * L2_BE_W));
  wait_idle();
endtask

task automatic test_ram_writes();
  for (int w = 0; w < RAM_WORDS; w++) begin
    write_word(L2_ADDR_W'(w * L2_BE_W), fill_word(w), '1);
  end
  wait_idle();
  write_word(16'h00a0, rand_word(), 32'h0000_ff0f);
  write_word(16'h0127, rand_word(), 32'h8000_0001);
  read_word(16'h00a0);
  read_word(16'h0120);
  // Word 3 reached through an alias far above the ROM window.
  write_word(16'h2060, rand_word(), 32'h00ff_ff00);
  read_word(16'h0064);
  read_word(16'hc060);
  wait_idle();
endtask

task automatic test_interleaved();
  for (int i = 0; i < 12; i++) begin
    if (i % 2 == 0) begin
      read_word(L2_ADDR_W'(BOOTROM_BASE + ((i * 3) % ROM_WORDS) * L2_BE_W));
    end else if (i % 4 == 1) begin
      write_word(L2_ADDR_W'(i * L2_BE_W), rand_word(), 32'hf0f0_0ff0);
    end else begin
      read_word(L2_ADDR_W'((i - 2) * L2_BE_W));
    end
  end
  wait_idle();
endtask

task automatic test_back_pressure();
  int stalls;
  int waited;
  stall_resp = 1'b1;
  for (int i = 0; i < RESP_FIFO_DEPTH; i++) begin
    send_request(MEM_RD, L2_ADDR_W'(BOOTROM_BASE + i * L2_BE_W), '0, '0, stalls);
    check_value("request wait cycles", stalls, 0);
  end
  @(negedge i_clk);
  i_req_valid = 1'b1;
  i_req_cmd = MEM_RD;
  i_req_addr = L2_ADDR_W'(BOOTROM_BASE + 5 * L2_BE_W);
  #1;
  check_value("o_req_ready", o_req_ready, 1'b0);
  @(negedge i_clk);
  i_req_valid = 1'b0;
  waited = 0;
  while (!o_resp_valid) begin
    waited++;
    if (waited > max_wait) begin
      fail_run("Timed out waiting for o_resp_valid while stalled.");
    end
    @(negedge i_clk);
  end
  repeat (8) @(negedge i_clk);
  // No ROM credit comes back while every response is held.
  #1;
  check_value("o_req_ready", o_req_ready, 1'b0);
  stall_resp = 1'b0;
  wait_idle();
endtask

task automatic test_random_mix();
  logic [L2_ADDR_W-1:0] addr;
  mem_cmd_t             cmd;
  int                   stalls;
  random_resp = 1'b1;
  for (int i = 0; i < 200; i++) begin
    if ($urandom_range(0, 1)) begin
      addr = L2_ADDR_W'(BOOTROM_BASE + $urandom_range(0, BOOTROM_SIZE - 1));
    end else begin
      addr = L2_ADDR_W'($urandom);
      if (addr_in_rom(addr)) begin
        addr[15] = 1'b1;
      end
    end
    cmd = mem_cmd_t'($urandom_range(0, 1));
    send_request(cmd, addr, rand_word(), L2_BE_W'($urandom), stalls);
  end
  random_resp = 1'b0;
  wait_idle();
endtask

initial begin
  void'($urandom(69038));
  i_reset_n = 1'b0;
  i_req_valid = 1'b0;
  i_req_cmd = MEM_RD;
  i_req_addr = '0;
  i_req_tag = '0;
  i_req_data = '0;
  i_req_byte_en = '0;
  i_resp_ready = 1'b0;
  mon_enable = 1'b0;
  stall_resp = 1'b0;
  random_resp = 1'b0;
  held_valid = 1'b0;
  next_tag = '0;
  outstanding = 0;
  error_count = 0;
  for (int t = 0; t < 2**L2_TAG_W; t++) begin
    pending[t] = 1'b0;
    pending_rom[t] = 1'b0;
  end
  load_rom_model();
  repeat (8) @(posedge i_clk);
  @(negedge i_clk);
  i_reset_n = 1'b1;
  test_reset_state();
  mon_enable = 1'b1;
  test_rom_reads();
  test_ram_writes();
  test_interleaved();
  test_back_pressure();
  test_random_mix();
  if (error_count == 0) begin
    $display("Simulation completed successfully");
  end else begin
    $display("Simulation failed");
  end
  $finish;
end

endmodule
